// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int NUM_REGS = 8;
	// cycles the ram enable stays high per access
	localparam int RAM_WAIT = 2;
	localparam int WAIT_W = $clog2(RAM_WAIT + 1);

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;

	typedef enum logic [4:0] {
		OP_BEQZ  = 5'b00100,
		OP_NOP   = 5'b00001,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_LW    = 5'b10011,
		OP_SW    = 5'b11011,
		OP_RRR   = 5'b11100
	} op_e;

	// matches the funct field of rrr
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_AND = 2'b10,
		ALU_OR  = 2'b11
	} alu_op_e;

	typedef struct packed {
		op_e       op;
		reg_addr_t rx;
		reg_addr_t ry;
		reg_addr_t rz;
		alu_op_e   funct;
	} instr_r_t;

	typedef struct packed {
		op_e        op;
		reg_addr_t  rx;
		logic [7:0] imm8;
	} instr_i_t;

	// register view for rrr, lw, sw; immediate view for li, addiu, beqz
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

	typedef struct packed {
		logic      valid;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		alu_op_e   alu_op;
		logic      use_imm;
		reg_addr_t dest;
	} ex_ctrl_t;

	typedef struct packed {
		ex_ctrl_t ctrl;
		word_t    op_a;
		word_t    op_b;
		word_t    store_data;
		word_t    imm;
	} id_ex_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     value;
	} wb_t;

	typedef struct packed {
		logic  en;
		logic  we;
		word_t addr;
		word_t wdata;
	} ram_req_t;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire                     clk,
	input  wire                     arst_n,
	output cpu_pkg::word_t          inst_addr,
	input  wire cpu_pkg::instr_t    inst_data,
	output cpu_pkg::ram_req_t       ram_req,
	input  wire cpu_pkg::word_t     ram_rdata,
	output cpu_pkg::wb_t            wb
);
	import cpu_pkg::*;

	logic      hold;
	logic      redirect;
	word_t     redirect_pc;
	instr_t    id_inst;
	word_t     id_pc;
	logic      id_valid;
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	id_ex_t    ex;
	ram_req_t  mem_cmd;
	logic      mem_done;

	fetch_unit fetch_unit_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.hold        (hold),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst_data   (inst_data),
		.inst_addr   (inst_addr),
		.id_inst     (id_inst),
		.id_pc       (id_pc),
		.id_valid    (id_valid)
	);

	reg_file reg_file_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb        (wb)
	);

	decode_unit decode_unit_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.hold        (hold),
		.id_inst     (id_inst),
		.id_pc       (id_pc),
		.id_valid    (id_valid),
		.rd_addr_a   (rd_addr_a),
		.rd_addr_b   (rd_addr_b),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ex          (ex)
	);

	// execute, memory access and writeback share one stage
	exec_unit exec_unit_i (
		.ex        (ex),
		.hold      (hold),
		.ram_rdata (ram_rdata),
		.mem_done  (mem_done),
		.mem_cmd   (mem_cmd),
		.wb        (wb)
	);

	mem_fsm mem_fsm_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.mem_cmd  (mem_cmd),
		.ram_req  (ram_req),
		.hold     (hold),
		.mem_done (mem_done)
	);

endmodule

`default_nettype wire

// File: design/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     hold,
	input  wire cpu_pkg::instr_t    id_inst,
	input  wire cpu_pkg::word_t     id_pc,
	input  wire                     id_valid,
	output cpu_pkg::reg_addr_t      rd_addr_a,
	output cpu_pkg::reg_addr_t      rd_addr_b,
	input  wire cpu_pkg::word_t     rd_data_a,
	input  wire cpu_pkg::word_t     rd_data_b,
	output logic                    redirect,
	output cpu_pkg::word_t          redirect_pc,
	output cpu_pkg::id_ex_t         ex
);
	import cpu_pkg::*;

	ex_ctrl_t ctrl_d;
	ex_ctrl_t ctrl_q;
	word_t    op_a_d;
	word_t    imm_d;
	word_t    imm_sext;
	word_t    op_a_q;
	word_t    op_b_q;
	word_t    store_q;
	word_t    imm_q;
	logic     is_beqz;

	assign imm_sext = {{8{id_inst.i.imm8[7]}}, id_inst.i.imm8};

	always_comb begin
		ctrl_d = '0;
		ctrl_d.valid = 1'b1;
		ctrl_d.alu_op = ALU_ADD;
		// rx sits in the same bits in both views
		rd_addr_a = id_inst.r.rx;
		rd_addr_b = id_inst.r.ry;
		op_a_d = rd_data_a;
		imm_d = imm_sext;
		is_beqz = 1'b0;
		case (id_inst.r.op)
			OP_LI: begin
				// li is 0 + zero-extended imm
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.dest = id_inst.i.rx;
				op_a_d = '0;
				imm_d = {8'h00, id_inst.i.imm8};
			end
			OP_ADDIU: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.dest = id_inst.i.rx;
			end
			OP_RRR: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.alu_op = id_inst.r.funct;
				ctrl_d.dest = id_inst.r.rz;
			end
			OP_LW: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.mem_read = 1'b1;
				ctrl_d.dest = id_inst.r.ry;
			end
			OP_SW: begin
				ctrl_d.mem_write = 1'b1;
			end
			OP_BEQZ: begin
				is_beqz = 1'b1;
			end
			// nop and unknown opcodes carry no effect
			default: ;
		endcase
	end

	// branch tested on the forwarded rx value
	assign redirect = id_valid && is_beqz && (rd_data_a == '0);
	assign redirect_pc = id_pc + word_t'(1) + imm_sext;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q <= '0;
			op_a_q <= '0;
			op_b_q <= '0;
			store_q <= '0;
			imm_q <= '0;
		end else if (!hold) begin
			ctrl_q <= id_valid ? ctrl_d : '0;
			op_a_q <= op_a_d;
			op_b_q <= rd_data_b;
			store_q <= rd_data_b;
			imm_q <= imm_d;
		end
	end

	assign ex = '{ctrl: ctrl_q, op_a: op_a_q, op_b: op_b_q, store_data: store_q, imm: imm_q};

	a_redirect_valid: assert property (@(posedge clk) disable iff (!arst_n)
		redirect |-> id_valid);

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire cpu_pkg::id_ex_t    ex,
	input  wire                     hold,
	input  wire cpu_pkg::word_t     ram_rdata,
	input  wire                     mem_done,
	output cpu_pkg::ram_req_t       mem_cmd,
	output cpu_pkg::wb_t            wb
);
	import cpu_pkg::*;

	word_t alu_b;
	word_t alu_y;
	logic  load_done;

	assign alu_b = ex.ctrl.use_imm ? ex.imm : ex.op_b;

	always_comb begin
		case (ex.ctrl.alu_op)
			ALU_ADD: alu_y = ex.op_a + alu_b;
			ALU_SUB: alu_y = ex.op_a - alu_b;
			ALU_AND: alu_y = ex.op_a & alu_b;
			ALU_OR:  alu_y = ex.op_a | alu_b;
			default: alu_y = ex.op_a + alu_b;
		endcase
	end

	// address is rx directly, no offset
	always_comb begin
		mem_cmd.en = ex.ctrl.valid && (ex.ctrl.mem_read || ex.ctrl.mem_write);
		mem_cmd.we = ex.ctrl.valid && ex.ctrl.mem_write;
		mem_cmd.addr = ex.op_a;
		mem_cmd.wdata = ex.store_data;
	end

	assign load_done = mem_done && ex.ctrl.mem_read;

	// a load only writes in its done cycle
	always_comb begin
		wb.en = ex.ctrl.valid && ex.ctrl.reg_write && !hold
			&& (!ex.ctrl.mem_read || mem_done);
		wb.addr = ex.ctrl.dest;
		wb.value = load_done ? ram_rdata : alu_y;
	end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     hold,
	input  wire                     redirect,
	input  wire cpu_pkg::word_t     redirect_pc,
	input  wire cpu_pkg::instr_t    inst_data,
	output cpu_pkg::word_t          inst_addr,
	output cpu_pkg::instr_t         id_inst,
	output cpu_pkg::word_t          id_pc,
	output logic                    id_valid
);
	import cpu_pkg::*;

	word_t pc;

	// pc, slot valid flag and fetch/decode register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			id_valid <= 1'b0;
			id_inst <= '0;
			id_pc <= '0;
		end else if (!hold) begin
			// taken branch in decode wins over the sequential pc
			pc <= redirect ? redirect_pc : pc + word_t'(1);
			id_valid <= 1'b1;
			// the delay slot lands here too
			id_inst <= inst_data;
			id_pc <= pc;
		end
	end

	assign inst_addr = pc;

endmodule

`default_nettype wire

// File: design/mem_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fsm (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire cpu_pkg::ram_req_t  mem_cmd,
	output cpu_pkg::ram_req_t       ram_req,
	output logic                    hold,
	output logic                    mem_done
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		FINISH
	} state_e;

	state_e   state;
	state_e   state_next;
	ram_req_t req_q;
	logic     start;
	logic     expired;

	wait_timer wait_timer_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.expired (expired)
	);

	// finish also accepts a new command since the pipeline has already moved on
	assign start = (state != ACCESS) && mem_cmd.en;
	assign mem_done = (state == ACCESS) && expired;
	assign hold = start || ((state == ACCESS) && !expired);

	always_comb begin
		state_next = state;
		case (state)
			IDLE:    if (start) state_next = ACCESS;
			ACCESS:  if (expired) state_next = FINISH;
			FINISH:  state_next = start ? ACCESS : IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_q <= '0;
		end else if (start) begin
			req_q <= mem_cmd;
		end
	end

	always_comb begin
		ram_req = req_q;
		ram_req.en = (state == ACCESS);
		ram_req.we = (state == ACCESS) && req_q.we;
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ram_req.en && $past(ram_req.en) |->
			$stable(ram_req.addr) && $stable(ram_req.we) && $stable(ram_req.wdata));

	a_req_length: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ram_req.en) |-> ##RAM_WAIT $fell(ram_req.en));

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire cpu_pkg::reg_addr_t rd_addr_a,
	input  wire cpu_pkg::reg_addr_t rd_addr_b,
	output cpu_pkg::word_t          rd_data_a,
	output cpu_pkg::word_t          rd_data_b,
	input  wire cpu_pkg::wb_t       wb
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.addr] <= wb.value;
		end
	end

	// same-cycle writeback bypasses the array
	assign rd_data_a = (wb.en && wb.addr == rd_addr_a) ? wb.value : regs[rd_addr_a];
	assign rd_data_b = (wb.en && wb.addr == rd_addr_b) ? wb.value : regs[rd_addr_b];

	// a writeback targets a real register and carries a known value
	a_wb_valid: assert property (@(posedge clk) disable iff (!arst_n)
		wb.en |-> (int'(wb.addr) < NUM_REGS) && !$isunknown(wb.value));

endmodule

`default_nettype wire

// File: design/wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
	input  wire  clk,
	input  wire  arst_n,
	input  wire  start,
	output logic expired
);
	import cpu_pkg::*;

	logic [WAIT_W-1:0] count;
	logic              running;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			running <= 1'b0;
		end else if (start) begin
			count <= WAIT_W'(RAM_WAIT - 1);
			running <= 1'b1;
		end else if (running) begin
			if (count == '0) begin
				running <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign expired = running && (count == '0);

	a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> !running);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the cpu testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module cpu_tb -o cpu_tb_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/cpu_tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// File: sim.f
design/cpu_pkg.sv
design/wait_timer.sv
design/mem_fsm.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/exec_unit.sv
design/cpu_top.sv
test/mem_model.sv
test/cpu_tb.sv

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	localparam int PROG_LEN = 60;
	localparam int CYCLE_LIMIT = PROG_LEN * (RAM_WAIT + 1) * 2 + 50;
	localparam int DRAIN_CYCLES = 8;

	logic     clk;
	logic     arst_n;
	word_t    inst_addr;
	instr_t   inst_data;
	ram_req_t ram_req;
	word_t    ram_rdata;
	wb_t      wb;

	instr_t   prog [PROG_LEN];
	word_t    ref_regs [NUM_REGS];
	word_t    ref_mem [word_t];
	wb_t      exp_wb [$];
	ram_req_t exp_st [$];
	integer   seed;
	int       cycle;
	int       passed_checks;
	int       fails [1:6];
	int       pulse_len;
	ram_req_t prev_req;
	logic     first_run_cycle;

	cpu_top cpu_top_i (.clk, .arst_n, .inst_addr, .inst_data,
		.ram_req, .ram_rdata, .wb);
	mem_model mem_model_i (.clk, .inst_addr, .inst_data, .ram_req, .ram_rdata);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic word_t sign_extend(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic word_t initial_ram_word(input word_t a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1: return "reset state";
			2: return "writeback values";
			3: return "writeback order";
			4: return "stores";
			5: return "ram bus protocol";
			default: return "completion";
		endcase
	endfunction

	task automatic check_value(input int t, input string name, input word_t exp, input word_t got);
		assert (got == exp) passed_checks++;
		else begin
			$display("Mismatch %s: expected %h, got %h", name, exp, got);
			fails[t]++;
		end
	endtask

	task automatic report_problem(input int t, input string msg);
		$display("%s: %s", test_name(t), msg);
		fails[t]++;
	endtask

	task automatic build_program();
		int     sel;
		logic   prev_branch;
		instr_t w;
		prev_branch = 1'b0;
		for (int k = 0; k < PROG_LEN; k++) begin
			sel = int'($unsigned($random(seed)) % 11);
			w = instr_t'(16'($random(seed)));
			// no branch inside a delay slot
			if (prev_branch && sel == 9) begin
				sel = 0;
			end
			case (sel)
				0, 1: begin
					w.i.op = OP_LI;
					// plenty of zero registers so beqz is taken often
					if (w.i.imm8[0]) begin
						w.i.imm8 = 8'h00;
					end
				end
				2: w.i.op = OP_ADDIU;
				3, 4, 5: w.r.op = OP_RRR;
				6: w.r.op = OP_LW;
				7: w.r.op = OP_SW;
				8: w.i.op = OP_NOP;
				9: begin
					w.i.op = OP_BEQZ;
					w.i.imm8 = 8'($unsigned($random(seed)) % 6);
				end
				// unknown opcode
				default: w = instr_t'({5'b00000, 11'($random(seed))});
			endcase
			prev_branch = (sel == 9);
			prog[k] = w;
		end
	endtask

	task automatic retire_write(input reg_addr_t r, input word_t v);
		wb_t e;
		e.en = 1'b1;
		e.addr = r;
		e.value = v;
		ref_regs[r] = v;
		exp_wb.push_back(e);
	endtask

	// isa model with one branch delay slot
	task automatic run_reference();
		int       pc;
		int       next_pc;
		int       after;
		instr_t   w;
		word_t    a;
		word_t    b;
		word_t    y;
		ram_req_t s;
		for (int k = 0; k < NUM_REGS; k++) begin
			ref_regs[k] = '0;
		end
		pc = 0;
		next_pc = 1;
		while (pc < PROG_LEN) begin
			w = prog[pc];
			after = next_pc + 1;
			a = ref_regs[w.r.rx];
			b = ref_regs[w.r.ry];
			case (w.r.op)
				OP_LI: retire_write(w.i.rx, {8'h00, w.i.imm8});
				OP_ADDIU: retire_write(w.i.rx, a + sign_extend(w.i.imm8));
				OP_RRR: begin
					case (w.r.funct)
						ALU_ADD: y = a + b;
						ALU_SUB: y = a - b;
						ALU_AND: y = a & b;
						default: y = a | b;
					endcase
					retire_write(w.r.rz, y);
				end
				OP_LW: retire_write(w.r.ry, ref_mem.exists(a) ? ref_mem[a] : initial_ram_word(a));
				OP_SW: begin
					ref_mem[a] = b;
					s.en = 1'b1;
					s.we = 1'b1;
					s.addr = a;
					s.wdata = b;
					exp_st.push_back(s);
				end
				OP_BEQZ: begin
					if (a == '0) begin
						after = int'(word_t'(pc) + 16'd1 + sign_extend(w.i.imm8));
					end
				end
				default: ;
			endcase
			pc = next_pc;
			next_pc = after;
		end
	endtask

	task automatic finish_run();
		int total;
		total = 0;
		for (int t = 1; t <= 6; t++) begin
			total += fails[t];
		end
		for (int t = 2; t <= 6; t++) begin
			$display("%s: %0d errors", test_name(t), fails[t]);
		end
		$display("checks passed: %0d, failed: %0d", passed_checks, total);
		if (total == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// reset state, sampled before each rising edge takes effect
	always @(posedge clk) begin
		if ((!arst_n || first_run_cycle) && cycle > 0) begin
			check_value(1, "inst_addr", '0, inst_addr);
			check_value(1, "wb.en", '0, word_t'(wb.en));
			check_value(1, "ram_req.en", '0, word_t'(ram_req.en));
		end
		if (first_run_cycle && arst_n) begin
			$display("%s: %0d errors", test_name(1), fails[1]);
		end
		first_run_cycle = !arst_n;
	end

	// writebacks, stores and bus protocol
	always @(posedge clk) begin
		wb_t      exp_w;
		ram_req_t exp_s;
		if (arst_n && wb.en) begin
			if (exp_wb.size() == 0) begin
				report_problem(3, $sformatf("unexpected writeback to r%0d", wb.addr));
			end else begin
				exp_w = exp_wb.pop_front();
				check_value(3, "wb.addr", word_t'(exp_w.addr), word_t'(wb.addr));
				check_value(2, "wb.value", exp_w.value, wb.value);
			end
		end
		if (arst_n && ram_req.en && !prev_req.en && ram_req.we) begin
			if (exp_st.size() == 0) begin
				report_problem(4, "a store reached the ram with none expected");
			end else begin
				exp_s = exp_st.pop_front();
				check_value(4, "ram_req.addr", exp_s.addr, ram_req.addr);
				check_value(4, "ram_req.wdata", exp_s.wdata, ram_req.wdata);
			end
		end
		if (ram_req.en) begin
			if (prev_req.en) begin
				check_value(5, "ram_req.addr", prev_req.addr, ram_req.addr);
				check_value(5, "ram_req.we", word_t'(prev_req.we), word_t'(ram_req.we));
				check_value(5, "ram_req.wdata", prev_req.wdata, ram_req.wdata);
			end
			pulse_len = pulse_len + 1;
		end else if (prev_req.en) begin
			check_value(5, "ram_req.en cycles", word_t'(RAM_WAIT), word_t'(pulse_len));
			pulse_len = 0;
		end
		// only a load writes back, and only in the last enable cycle
		if (wb.en && ram_req.en) begin
			assert (pulse_len == RAM_WAIT && !ram_req.we) passed_checks++;
			else report_problem(5, "writeback while the ram access was still running");
		end
		prev_req = ram_req;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			report_problem(6, "program did not finish before the cycle limit");
			finish_run();
		end
	end

	initial begin
		seed = 32'h149a;
		arst_n = 1'b0;
		cycle = 0;
		passed_checks = 0;
		pulse_len = 0;
		prev_req = '0;
		first_run_cycle = 1'b0;
		for (int t = 1; t <= 6; t++) begin
			fails[t] = 0;
		end
		@(negedge clk);
		build_program();
		for (int k = 0; k < PROG_LEN; k++) begin
			mem_model_i.load_inst(k, prog[k]);
		end
		run_reference();
		$display("program of %0d words: %0d writebacks and %0d stores expected",
			PROG_LEN, exp_wb.size(), exp_st.size());
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		while (exp_wb.size() != 0 || exp_st.size() != 0) begin
			@(negedge clk);
		end
		// a few more cycles to catch stray writebacks
		repeat (DRAIN_CYCLES) @(negedge clk);
		finish_run();
	end

endmodule

`default_nettype wire

// File: test/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input  wire                     clk,
	input  wire cpu_pkg::word_t     inst_addr,
	output cpu_pkg::instr_t         inst_data,
	input  wire cpu_pkg::ram_req_t  ram_req,
	output cpu_pkg::word_t          ram_rdata
);
	import cpu_pkg::*;

	localparam int IMEM_DEPTH = 128;
	localparam int DMEM_DEPTH = 65536;

	instr_t iram [IMEM_DEPTH];
	word_t  dram [DMEM_DEPTH];
	instr_t nop_word;

	assign nop_word = instr_t'({OP_NOP, 11'd0});

	// data ram starts with a pattern of the full address
	initial begin
		for (int a = 0; a < DMEM_DEPTH; a++) begin
			dram[a] = {a[7:0], a[15:8]} ^ 16'h3c5a;
		end
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			iram[a] = instr_t'({OP_NOP, 11'd0});
		end
	end

	task automatic load_inst(input int addr, input instr_t word);
		iram[addr] = word;
	endtask

	// everything past the instruction array reads as nop
	assign inst_data = (inst_addr < word_t'(IMEM_DEPTH)) ? iram[inst_addr[6:0]] : nop_word;
	assign ram_rdata = dram[ram_req.addr];

	always @(posedge clk) begin
		if (ram_req.en && ram_req.we) begin
			dram[ram_req.addr] <= ram_req.wdata;
		end
	end

endmodule

`default_nettype wire
